// ==== logic/dcache_consts.svh ====
// Geometry of the L1 data cache, fixed at 4 ways x 16 sets x 64-byte lines
// Address fields must add up to DC_ADDR_W; nothing checks this at elaboration
// Status 0 marks an invalid line, so a valid line never ages below DC_STAT_FLOOR
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Address split, tag | index | offset
`define DC_ADDR_W       32
`define DC_TAG_W        22
`define DC_INDEX_W      4
`define DC_OFFSET_W     6

`define DC_WAYS         4
`define DC_SETS         16
`define DC_WAY_W        2

`define DC_LINE_BYTES   64
`define DC_LINE_W       512
`define DC_WORD_W       32

// LRU status per line
`define DC_STAT_W       2
`define DC_STAT_INVALID 2'd0
`define DC_STAT_NEWEST  2'd3
`define DC_STAT_FLOOR   2'd1    // Aging stops here

// Operation code and upload size widths
`define DC_OP_W         3
`define DC_SIZE_W       2

`endif

// ==== logic/dcache_pkg.sv ====
// Shared types of the data cache
// Needs the geometry macros, pulled in here through the consts header
`default_nettype none
`include "dcache_consts.svh"

package dcache_pkg;

	// One operation per cycle, picked by the controller
	typedef enum logic [`DC_OP_W-1:0] {
		OP_IDLE,
		OP_READ,
		OP_WRITE,
		OP_UPLOAD,
		OP_REMOVE
	} dc_op_e;

	// Upload size, encoded as on iUP_ORDER
	typedef enum logic [`DC_SIZE_W-1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2,
		SIZE_NONE = 2'd3    // Writes nothing
	} dc_size_e;

	typedef struct packed {
		logic [`DC_TAG_W-1:0]    tag;
		logic [`DC_INDEX_W-1:0]  index;
		logic [`DC_OFFSET_W-1:0] offset;
	} dc_addr_t;

	// Request seen by both datapaths in the same cycle
	typedef struct packed {
		dc_op_e                op;
		dc_addr_t              addr;
		dc_size_e              size;
		logic [`DC_WORD_W-1:0] word;    // Upload data
	} dc_req_t;

	// Lookup result; on a write, way is the target line
	typedef struct packed {
		logic                 hit;
		logic [`DC_WAY_W-1:0] way;
	} dc_way_sel_t;

endpackage

`default_nettype wire

// ==== logic/dcache_ctrl.sv ====
// Picks one operation per cycle and owns the read result flags
// Priority is remove, upload, write, read; a refused request must be held
// by the requester until it is taken
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_ctrl
	import dcache_pkg::*;
(
	input wire                    iCLOCK,
	input wire                    inRESET,
	input wire                    iREMOVE,
	input wire                    iRD_REQ,
	input wire  [`DC_ADDR_W-1:0]  iRD_ADDR,
	input wire                    iRD_BUSY,
	input wire                    iUP_REQ,
	input wire  [`DC_SIZE_W-1:0]  iUP_ORDER,
	input wire  [`DC_ADDR_W-1:0]  iUP_ADDR,
	input wire  [`DC_WORD_W-1:0]  iUP_DATA,
	input wire                    iWR_REQ,
	input wire  [`DC_ADDR_W-1:0]  iWR_ADDR,
	output logic                  oRD_BUSY,
	output logic                  oWR_BUSY,
	output logic                  oRD_VALID,
	output logic                  oRD_HIT,
	input wire  dc_way_sel_t      sel,
	output dc_req_t               req
);

	logic rd_held;    // Result waiting on the consumer

	assign rd_held  = oRD_VALID && iRD_BUSY;
	assign oWR_BUSY = iUP_REQ;
	assign oRD_BUSY = iWR_REQ || iUP_REQ || rd_held;

	always_comb begin
		req.word = iUP_DATA;
		req.size = SIZE_NONE;
		req.addr = dc_addr_t'(iRD_ADDR);
		if (iREMOVE) begin
			req.op = OP_REMOVE;
		end else if (iUP_REQ) begin
			req.op   = OP_UPLOAD;
			req.addr = dc_addr_t'(iUP_ADDR);
			req.size = dc_size_e'(iUP_ORDER);
		end else if (iWR_REQ) begin
			req.op   = OP_WRITE;
			req.addr = dc_addr_t'(iWR_ADDR);
		end else if (iRD_REQ && !oRD_BUSY) begin
			req.op = OP_READ;
		end else begin
			req.op = OP_IDLE;
		end
	end

	// Read result flags, data lives in the data array
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			oRD_VALID <= 1'b0;
			oRD_HIT   <= 1'b0;
		end else if (iREMOVE) begin
			oRD_VALID <= 1'b0;
			oRD_HIT   <= 1'b0;
		end else if (req.op == OP_READ) begin
			oRD_VALID <= 1'b1;
			oRD_HIT   <= sel.hit;
		end else if (!rd_held) begin
			// Delivered or empty, nothing new behind it
			oRD_VALID <= 1'b0;
			oRD_HIT   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/dcache_tag_store.sv ====
// Tag and LRU status per way and set, with the combinational lookup
// Lookup is on req.addr in the same cycle; updates land at the clock edge
// Tags are not cleared by reset or remove, only the status goes to invalid
// Aging happens on a write or a read hit, never on an upload
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_tag_store
	import dcache_pkg::*;
(
	input wire            iCLOCK,
	input wire            inRESET,
	input wire dc_req_t   req,
	output dc_way_sel_t   sel
);

	logic [`DC_TAG_W-1:0]  tag_q  [`DC_WAYS][`DC_SETS];
	logic [`DC_STAT_W-1:0] stat_q [`DC_WAYS][`DC_SETS];

	logic [`DC_INDEX_W-1:0] idx;
	logic [`DC_WAYS-1:0]    tag_match;      // Tag equal, valid or not
	logic [`DC_WAYS-1:0]    valid_match;
	logic [`DC_WAY_W-1:0]   tag_way;
	logic [`DC_WAY_W-1:0]   hit_way;
	logic [`DC_WAY_W-1:0]   victim_way;
	logic                   access;

	assign idx = req.addr.index;

	always_comb begin
		tag_match   = '0;
		valid_match = '0;
		tag_way     = '0;
		hit_way     = '0;
		// Walk down so the lowest matching way wins
		for (int w = `DC_WAYS - 1; w >= 0; w--) begin
			if (tag_q[w][idx] == req.addr.tag) begin
				tag_match[w] = 1'b1;
				tag_way      = w[`DC_WAY_W-1:0];
				if (stat_q[w][idx] != `DC_STAT_INVALID) begin
					valid_match[w] = 1'b1;
					hit_way        = w[`DC_WAY_W-1:0];
				end
			end
		end
	end

	// Oldest line, lowest way on ties; invalid lines come first
	always_comb begin
		victim_way = '0;
		for (int w = 1; w < `DC_WAYS; w++) begin
			if (stat_q[w][idx] < stat_q[victim_way][idx]) begin
				victim_way = w[`DC_WAY_W-1:0];
			end
		end
	end

	always_comb begin
		sel.hit = |valid_match;
		if (req.op == OP_WRITE) begin
			sel.way = (|tag_match) ? tag_way : victim_way;    // Refresh or replace
		end else begin
			sel.way = hit_way;
		end
	end

	assign access = (req.op == OP_WRITE) || (req.op == OP_READ && sel.hit);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				for (int s = 0; s < `DC_SETS; s++) begin
					stat_q[w][s] <= `DC_STAT_INVALID;
				end
			end
		end else if (req.op == OP_REMOVE) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				for (int s = 0; s < `DC_SETS; s++) begin
					stat_q[w][s] <= `DC_STAT_INVALID;
				end
			end
		end else if (access) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (int'(sel.way) == w) begin
					stat_q[w][idx] <= `DC_STAT_NEWEST;
				end else if (stat_q[w][idx] > `DC_STAT_FLOOR) begin
					stat_q[w][idx] <= stat_q[w][idx] - 1'b1;    // Age the rest of the set
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (req.op == OP_WRITE) begin
			tag_q[sel.way][idx] <= req.addr.tag;
		end
	end

endmodule

`default_nettype wire

// ==== logic/dcache_data_array.sv ====
// Line storage for all four ways, one write port with byte enables
// Read word is registered and holds until the next read is accepted
// A miss loads zero; after reset the word is undefined until the first read
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_data_array
	import dcache_pkg::*;
(
	input wire                       iCLOCK,
	input wire dc_req_t              req,
	input wire dc_way_sel_t          sel,
	input wire [`DC_LINE_W-1:0]      line,
	output logic [`DC_WORD_W-1:0]    rd_word
);

	logic [`DC_LINE_W-1:0] lines_q [`DC_WAYS][`DC_SETS];

	logic                      line_we;
	logic [`DC_LINE_BYTES-1:0] byte_en;
	logic [`DC_LINE_W-1:0]     wr_data;
	logic [`DC_WORD_W-1:0]     word_sel;

	// Enabled bytes of an upload, aligned down to the access size
	function automatic logic [`DC_LINE_BYTES-1:0] upload_be(
		input logic [`DC_OFFSET_W-1:0] off,
		input dc_size_e                size
	);
		logic [`DC_LINE_BYTES-1:0] be;
		case (size)
			SIZE_BYTE: be = 64'h1 << off;
			SIZE_HALF: be = 64'h3 << {off[`DC_OFFSET_W-1:1], 1'b0};
			SIZE_WORD: be = 64'hf << {off[`DC_OFFSET_W-1:2], 2'b00};
			default:   be = '0;
		endcase
		return be;
	endfunction

	always_comb begin
		line_we = 1'b0;
		byte_en = '0;
		wr_data = line;
		if (req.op == OP_WRITE) begin
			line_we = 1'b1;
			byte_en = '1;    // Whole line
		end else if (req.op == OP_UPLOAD && sel.hit) begin
			line_we = 1'b1;
			byte_en = upload_be(req.addr.offset, req.size);
			wr_data = {(`DC_LINE_W / `DC_WORD_W){req.word}};    // Word in every lane
		end
	end

	// Word at offset[5:2] of the looked-up way
	assign word_sel =
		lines_q[sel.way][req.addr.index][{req.addr.offset[`DC_OFFSET_W-1:2], 5'd0} +: `DC_WORD_W];

	always_ff @(posedge iCLOCK) begin
		if (line_we) begin
			for (int b = 0; b < `DC_LINE_BYTES; b++) begin
				if (byte_en[b]) begin
					lines_q[sel.way][req.addr.index][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
		if (req.op == OP_READ) begin
			rd_word <= sel.hit ? word_sel : '0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
// Four-way set-associative L1 data cache, 16 sets of 64-byte lines
// One operation per cycle: remove, then upload, then write, then read
// Read result comes one cycle after acceptance and holds while iRD_BUSY is high
// Uploads to an absent line are dropped; there is no refill path
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_top
	import dcache_pkg::*;
(
	input wire                      iCLOCK,
	input wire                      inRESET,
	input wire                      iREMOVE,
	// Read
	input wire                      iRD_REQ,
	input wire  [`DC_ADDR_W-1:0]    iRD_ADDR,
	input wire                      iRD_BUSY,
	output logic                    oRD_BUSY,
	output logic                    oRD_VALID,
	output logic                    oRD_HIT,
	output logic [`DC_WORD_W-1:0]   oRD_DATA,
	// Upload
	input wire                      iUP_REQ,
	input wire  [`DC_SIZE_W-1:0]    iUP_ORDER,
	input wire  [`DC_ADDR_W-1:0]    iUP_ADDR,
	input wire  [`DC_WORD_W-1:0]    iUP_DATA,
	// Line write
	input wire                      iWR_REQ,
	output logic                    oWR_BUSY,
	input wire  [`DC_ADDR_W-1:0]    iWR_ADDR,
	input wire  [`DC_LINE_W-1:0]    iWR_DATA
);

	dc_req_t     req;    // Operation of this cycle
	dc_way_sel_t sel;    // Lookup on req.addr

	dcache_ctrl ctrl_i (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.iREMOVE   (iREMOVE),
		.iRD_REQ   (iRD_REQ),
		.iRD_ADDR  (iRD_ADDR),
		.iRD_BUSY  (iRD_BUSY),
		.iUP_REQ   (iUP_REQ),
		.iUP_ORDER (iUP_ORDER),
		.iUP_ADDR  (iUP_ADDR),
		.iUP_DATA  (iUP_DATA),
		.iWR_REQ   (iWR_REQ),
		.iWR_ADDR  (iWR_ADDR),
		.oRD_BUSY  (oRD_BUSY),
		.oWR_BUSY  (oWR_BUSY),
		.oRD_VALID (oRD_VALID),
		.oRD_HIT   (oRD_HIT),
		.sel       (sel),
		.req       (req)
	);

	dcache_tag_store tag_store_i (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.req     (req),
		.sel     (sel)
	);

	dcache_data_array data_array_i (
		.iCLOCK  (iCLOCK),
		.req     (req),
		.sel     (sel),
		.line    (iWR_DATA),
		.rd_word (oRD_DATA)
	);

endmodule

`default_nettype wire

// ==== verif/dcache_props.sv ====
// Concurrent assertions on the cache controller, attached by bind
// The read word lives in the data array and is not visible here
`timescale 1ns/1ps
`default_nettype none

module dcache_props (
	input wire iCLOCK,
	input wire inRESET,
	input wire iREMOVE,
	input wire iRD_BUSY,
	input wire iUP_REQ,
	input wire oRD_VALID,
	input wire oRD_HIT,
	input wire oWR_BUSY
);

	int fail_cnt = 0;    // Failed assertions so far

	valid_low_in_reset: assert property (@(posedge iCLOCK) !inRESET |=> !oRD_VALID)
		else begin
			fail_cnt++;
			$error("read valid came up while reset was asserted");
		end

	// Result stays put while the consumer stalls
	held_result_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(oRD_VALID && iRD_BUSY && !iREMOVE) |=> (oRD_VALID && $stable(oRD_HIT)))
		else begin
			fail_cnt++;
			$error("held read result changed before delivery");
		end

	wr_busy_is_upload: assert property (@(posedge iCLOCK) oWR_BUSY == iUP_REQ)
		else begin
			fail_cnt++;
			$error("write busy does not follow the upload request");
		end

endmodule

bind dcache_ctrl dcache_props props_i (
	.iCLOCK    (iCLOCK),
	.inRESET   (inRESET),
	.iREMOVE   (iREMOVE),
	.iRD_BUSY  (iRD_BUSY),
	.iUP_REQ   (iUP_REQ),
	.oRD_VALID (oRD_VALID),
	.oRD_HIT   (oRD_HIT),
	.oWR_BUSY  (oWR_BUSY)
);

`default_nettype wire

// ==== verif/dcache_checker.sv ====
// Reference model of the cache, fed from the DUT ports
// Samples at the falling edge, when inputs and outputs are both settled
// Tags never written since reset are treated as matching nothing
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_checker
	import dcache_pkg::*;
(
	input wire                   iCLOCK,
	input wire                   inRESET,
	input wire                   iREMOVE,
	input wire                   iRD_REQ,
	input wire [`DC_ADDR_W-1:0]  iRD_ADDR,
	input wire                   iRD_BUSY,
	input wire                   oRD_BUSY,
	input wire                   oRD_VALID,
	input wire                   oRD_HIT,
	input wire [`DC_WORD_W-1:0]  oRD_DATA,
	input wire                   iUP_REQ,
	input wire [`DC_SIZE_W-1:0]  iUP_ORDER,
	input wire [`DC_ADDR_W-1:0]  iUP_ADDR,
	input wire [`DC_WORD_W-1:0]  iUP_DATA,
	input wire                   iWR_REQ,
	input wire                   oWR_BUSY,
	input wire [`DC_ADDR_W-1:0]  iWR_ADDR,
	input wire [`DC_LINE_W-1:0]  iWR_DATA,
	input wire [3:0]             test_id,
	output int                   errors,
	output int                   checks
);

	logic [`DC_TAG_W-1:0]  m_tag   [`DC_WAYS][`DC_SETS];
	logic                  m_known [`DC_WAYS][`DC_SETS];    // Tag written since reset
	logic [`DC_STAT_W-1:0] m_stat  [`DC_WAYS][`DC_SETS];
	logic [`DC_LINE_W-1:0] m_line  [`DC_WAYS][`DC_SETS];
	logic [`DC_WORD_W:0]   exp_q [$];    // Pending {hit, word}

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1:    return "read_after_write";
			4'd2:    return "miss";
			4'd3:    return "upload";
			4'd4:    return "replacement";
			4'd5:    return "backpressure";
			default: return "reset";
		endcase
	endfunction

	// Lowest way holding the tag, -1 if none
	function automatic int find_way(input dc_addr_t a, input bit any_state);
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (m_known[w][a.index] && m_tag[w][a.index] == a.tag &&
					(any_state || m_stat[w][a.index] != `DC_STAT_INVALID)) begin
				return w;
			end
		end
		return -1;
	endfunction

	// Expected {hit, word} of a read, zero word on a miss
	function automatic logic [`DC_WORD_W:0] ref_read(input dc_addr_t a);
		int w;
		w = find_way(a, 1'b0);
		if (w < 0) begin
			return '0;
		end
		return {1'b1, m_line[w][a.index][int'(a.offset[5:2]) * 32 +: 32]};
	endfunction

	// Accessed way becomes newest, ways at 2 or 3 age by one
	function automatic void touch(input int way, input logic [`DC_INDEX_W-1:0] idx);
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (w == way) begin
				m_stat[w][idx] = `DC_STAT_NEWEST;
			end else if (m_stat[w][idx] >= 2'd2) begin
				m_stat[w][idx] = m_stat[w][idx] - 2'd1;
			end
		end
	endfunction

	function automatic void model_write(input dc_addr_t a, input logic [`DC_LINE_W-1:0] data);
		int w;
		w = find_way(a, 1'b1);
		if (w < 0) begin
			w = 0;    // Oldest way, lowest index on ties
			for (int v = 1; v < `DC_WAYS; v++) begin
				if (m_stat[v][a.index] < m_stat[w][a.index]) begin
					w = v;
				end
			end
		end
		m_tag[w][a.index]   = a.tag;
		m_known[w][a.index] = 1'b1;
		m_line[w][a.index]  = data;
		touch(w, a.index);
	endfunction

	function automatic void model_upload(input dc_addr_t a, input logic [1:0] order,
			input logic [`DC_WORD_W-1:0] data);
		int w;
		int first;
		int n;
		w = find_way(a, 1'b0);
		first = int'(a.offset);
		n = 0;
		case (dc_size_e'(order))
			SIZE_BYTE: n = 1;
			SIZE_HALF: begin
				first = int'({a.offset[5:1], 1'b0});
				n = 2;
			end
			SIZE_WORD: begin
				first = int'({a.offset[5:2], 2'b00});
				n = 4;
			end
			default: n = 0;
		endcase
		if (w < 0) begin
			return;    // Absent line, nothing changes
		end
		for (int b = first; b < first + n; b++) begin
			m_line[w][a.index][8*b +: 8] = data[8*(b%4) +: 8];
		end
	endfunction

	task automatic check_val(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				test_name(test_id), what, expected, actual);
		end
	endtask

	always @(negedge iCLOCK) begin
		logic [`DC_WORD_W:0] exp;
		logic busy_exp;
		if (!inRESET) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				for (int s = 0; s < `DC_SETS; s++) begin
					m_stat[w][s]  = `DC_STAT_INVALID;
					m_known[w][s] = 1'b0;
				end
			end
			exp_q.delete();
			errors = 0;
			checks = 0;
		end else begin
			if (oRD_VALID && exp_q.size() == 0) begin
				errors++;
				$display("Error in %s: read result shown with no read accepted",
					test_name(test_id));
			end else if (!oRD_VALID && exp_q.size() != 0) begin
				errors++;
				$display("Error in %s: accepted read never produced a result",
					test_name(test_id));
				exp_q.delete();
			end else if (oRD_VALID && !iRD_BUSY) begin
				exp = exp_q.pop_front();    // Delivered this cycle
				check_val("rd_hit", 32'(exp[`DC_WORD_W]), 32'(oRD_HIT));
				check_val("rd_data", exp[`DC_WORD_W-1:0], oRD_DATA);
			end
			busy_exp = iWR_REQ || iUP_REQ || (oRD_VALID && iRD_BUSY);
			check_val("rd_busy", 32'(busy_exp), 32'(oRD_BUSY));
			check_val("wr_busy", 32'(iUP_REQ), 32'(oWR_BUSY));
			if (iREMOVE) begin
				for (int w = 0; w < `DC_WAYS; w++) begin
					for (int s = 0; s < `DC_SETS; s++) begin
						m_stat[w][s] = `DC_STAT_INVALID;
					end
				end
				exp_q.delete();    // Held result is dropped
			end else if (iUP_REQ) begin
				model_upload(dc_addr_t'(iUP_ADDR), iUP_ORDER, iUP_DATA);
			end else if (iWR_REQ) begin
				model_write(dc_addr_t'(iWR_ADDR), iWR_DATA);
			end else if (iRD_REQ && !busy_exp) begin
				exp = ref_read(dc_addr_t'(iRD_ADDR));
				if (exp[`DC_WORD_W]) begin
					touch(find_way(dc_addr_t'(iRD_ADDR), 1'b0), iRD_ADDR[9:6]);
				end
				exp_q.push_back(exp);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_dcache.sv ====
// Testbench for the L1 data cache with random stimulus from a fixed seed
// Inputs change 10 ns after the rising edge; dcache_checker judges the results
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module tb_dcache;

	localparam int N_FILL    = 32;    // Lines written in test 1
	localparam int N_READ    = 64;
	localparam int N_UP      = 24;
	localparam int N_MIX     = 300;
	localparam int CYC_LIMIT = 16 + 2 * (3 * N_FILL + N_READ + 2 * N_UP + 40) + N_MIX + 100;

	logic                   iCLOCK;
	logic                   inRESET;
	logic                   iREMOVE;
	logic                   iRD_REQ;
	logic [`DC_ADDR_W-1:0]  iRD_ADDR;
	logic                   iRD_BUSY;
	logic                   oRD_BUSY;
	logic                   oRD_VALID;
	logic                   oRD_HIT;
	logic [`DC_WORD_W-1:0]  oRD_DATA;
	logic                   iUP_REQ;
	logic [`DC_SIZE_W-1:0]  iUP_ORDER;
	logic [`DC_ADDR_W-1:0]  iUP_ADDR;
	logic [`DC_WORD_W-1:0]  iUP_DATA;
	logic                   iWR_REQ;
	logic                   oWR_BUSY;
	logic [`DC_ADDR_W-1:0]  iWR_ADDR;
	logic [`DC_LINE_W-1:0]  iWR_DATA;

	logic [3:0]            test_id;
	int                    errors;
	int                    checks;
	int                    cycle_cnt = 0;
	logic [`DC_ADDR_W-1:0] written [$];    // Lines expected present
	logic [`DC_TAG_W-1:0]  tags [5];
	logic                  rd_pend;
	logic                  wr_pend;

	dcache_top dut_i (.*);

	dcache_checker chk_i (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	always @(posedge iCLOCK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYC_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [`DC_LINE_W-1:0] rand_line();
		logic [`DC_LINE_W-1:0] l;
		for (int i = 0; i < `DC_LINE_W / 32; i++) begin
			l[32*i +: 32] = $urandom;
		end
		return l;
	endfunction

	function automatic logic [`DC_ADDR_W-1:0] rand_addr();
		return {22'($urandom) | 22'h1, 4'($urandom), 6'($urandom)};    // Tag never zero
	endfunction

	// Few tags in few sets so that the mixed test hits often
	function automatic logic [`DC_ADDR_W-1:0] pool_addr();
		return {22'(1 + $urandom % 6), 4'($urandom % 4), 6'($urandom)};
	endfunction

	function automatic logic [`DC_ADDR_W-1:0] with_offset(input logic [`DC_ADDR_W-1:0] a);
		return {a[`DC_ADDR_W-1:6], 6'($urandom)};
	endfunction

	task automatic next_cycle();
		@(posedge iCLOCK);
		#10;
	endtask

	// Keep the request up until an edge takes it
	task automatic wait_taken(input bit for_read);
		@(negedge iCLOCK);
		while (for_read ? oRD_BUSY : oWR_BUSY) begin
			next_cycle();
			@(negedge iCLOCK);
		end
		next_cycle();
	endtask

	task automatic write_line(input logic [`DC_ADDR_W-1:0] addr);
		iWR_REQ  = 1'b1;
		iWR_ADDR = addr;
		iWR_DATA = rand_line();
		wait_taken(1'b0);
		iWR_REQ = 1'b0;
	endtask

	task automatic read_word(input logic [`DC_ADDR_W-1:0] addr);
		iRD_REQ  = 1'b1;
		iRD_ADDR = addr;
		wait_taken(1'b1);
		iRD_REQ = 1'b0;
	endtask

	task automatic upload(input logic [`DC_ADDR_W-1:0] addr);
		iUP_REQ   = 1'b1;
		iUP_ADDR  = addr;
		iUP_ORDER = 2'($urandom);    // SIZE_NONE included
		iUP_DATA  = $urandom;
		next_cycle();
		iUP_REQ = 1'b0;
	endtask

	task automatic remove_all();
		iREMOVE = 1'b1;
		next_cycle();
		iREMOVE = 1'b0;
	endtask

	initial begin
		logic [`DC_ADDR_W-1:0] addr;
		void'($urandom(32'h05c9_f720));
		inRESET   = 1'b0;
		iREMOVE   = 1'b0;
		iRD_REQ   = 1'b0;
		iRD_ADDR  = '0;
		iRD_BUSY  = 1'b0;
		iUP_REQ   = 1'b0;
		iUP_ORDER = '0;
		iUP_ADDR  = '0;
		iUP_DATA  = '0;
		iWR_REQ   = 1'b0;
		iWR_ADDR  = '0;
		iWR_DATA  = '0;
		test_id   = 4'd0;
		rd_pend   = 1'b0;
		wr_pend   = 1'b0;
		repeat (16) @(posedge iCLOCK);
		#10;
		inRESET = 1'b1;

		test_id = 4'd1;    // Two lines in every set and every read hits
		for (int i = 0; i < N_FILL; i++) begin
			written.push_back({22'($urandom) | 22'h1, 4'(i), 6'd0});
			write_line(written[i]);
		end
		for (int i = 0; i < N_READ; i++) begin
			read_word(with_offset(written[$urandom % N_FILL]));
		end

		test_id = 4'd2;
		for (int i = 0; i < 8; i++) begin
			read_word(rand_addr());
		end
		iRD_BUSY = 1'b1;    // Last result still held when the remove comes
		remove_all();
		iRD_BUSY = 1'b0;
		for (int i = 0; i < N_FILL; i++) begin
			read_word(written[i]);
		end

		test_id = 4'd3;
		written.delete();
		for (int i = 0; i < 8; i++) begin
			written.push_back(rand_addr());
			write_line(written[i]);
		end
		for (int i = 0; i < N_UP; i++) begin
			addr = ($urandom % 2 == 0) ? with_offset(written[$urandom % 8]) : rand_addr();
			upload(addr);
			read_word(addr);
		end

		test_id = 4'd4;    // Five tags into set 7
		remove_all();
		for (int i = 0; i < 5; i++) begin
			tags[i] = 22'($urandom) | 22'h1;
		end
		for (int i = 0; i < 4; i++) begin
			write_line({tags[i], 4'd7, 6'd0});
			read_word({tags[0], 4'd7, 6'd4});
		end
		write_line({tags[4], 4'd7, 6'd0});
		for (int i = 0; i < 5; i++) begin
			read_word({tags[i], 4'd7, 6'd8});
		end

		test_id = 4'd5;
		for (int c = 0; c < N_MIX; c++) begin
			iRD_BUSY = ($urandom % 3) == 0;
			iUP_REQ  = ($urandom % 4) == 0;
			if (iUP_REQ) begin
				iUP_ADDR  = pool_addr();
				iUP_ORDER = 2'($urandom);
				iUP_DATA  = $urandom;
			end
			if (!rd_pend && ($urandom % 2) == 0) begin
				rd_pend  = 1'b1;
				iRD_REQ  = 1'b1;
				iRD_ADDR = pool_addr();
			end
			if (!wr_pend && ($urandom % 5) == 0) begin
				wr_pend  = 1'b1;
				iWR_REQ  = 1'b1;
				iWR_ADDR = pool_addr();
				iWR_DATA = rand_line();
			end
			@(negedge iCLOCK);
			if (rd_pend && !oRD_BUSY) begin
				rd_pend = 1'b0;
			end
			if (wr_pend && !oWR_BUSY) begin
				wr_pend = 1'b0;
			end
			next_cycle();
			iRD_REQ = rd_pend;    // Refused requests stay up
			iWR_REQ = wr_pend;
		end
		iRD_REQ  = 1'b0;
		iWR_REQ  = 1'b0;
		iUP_REQ  = 1'b0;
		iRD_BUSY = 1'b0;
		repeat (4) next_cycle();

		$display("Closing: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, dut_i.ctrl_i.props_i.fail_cnt);
		if (errors == 0 && dut_i.ctrl_i.props_i.fail_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== Makefile ====
# Verilator build for the L1 data cache testbench
VERILATOR  ?= verilator
TOP        := tb_dcache
FILELIST   := dcache_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := TESTS PASSED
FAIL_MSG   := TESTS FAILED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && ! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dcache_top.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_ctrl.sv
logic/dcache_tag_store.sv
logic/dcache_data_array.sv
logic/dcache_top.sv
verif/dcache_props.sv
verif/dcache_checker.sv
verif/tb_dcache.sv
